// ==== ao_peripheral_subsystem.f ====
+incdir+source
source/ao_periph_pkg.sv
source/ao_bus_ctrl.sv
source/soc_ctrl_regs.sv
source/ao_timer.sv
source/fast_intr_ctrl.sv
source/gpio_ao.sv
source/ao_peripheral_subsystem.sv
test/tb_ao_peripheral_subsystem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the always-on peripheral subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f ao_peripheral_subsystem.f \
  --top-module tb_ao_peripheral_subsystem \
  -o sim_tb

sim_out=$(./obj_dir/sim_tb 2>&1) || true
echo "$sim_out"

if echo "$sim_out" | grep -q "^SIMULATION PASSED$"; then
  exit 0
fi
exit 1

// ==== test/tb_ao_peripheral_subsystem.sv ====
//********************************************************************
// Testbench for the always-on peripheral subsystem: random bus
// traffic checked against a register model, pins and timer
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module tb_ao_peripheral_subsystem;

  localparam int RESET_CYCLES   = 10;
  localparam int N_RAND         = 120;
  localparam int N_UNMAPPED     = 24;
  localparam int N_GPIO         = 8;
  localparam int N_PULSE        = 6;
  localparam int MAX_CMP        = 40;
  localparam int PLANNED_OPS    = N_RAND + N_UNMAPPED + 3 * N_GPIO + 2 * N_PULSE + MAX_CMP + 20;
  localparam int CYCLES_PER_OP  = 8;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + PLANNED_OPS * CYCLES_PER_OP;

  logic                      clk_i = 1'b0;
  logic                      rst_n_i;
  ao_periph_pkg::obi_req_t   bus_req_i;
  ao_periph_pkg::obi_rsp_t   bus_rsp_o;
  logic                      boot_select_i;
  logic                      exit_valid_o;
  ao_periph_pkg::data_t      exit_value_o;
  logic                      timer_intr_o;
  ao_periph_pkg::fast_intr_t fast_intr_i;
  ao_periph_pkg::fast_intr_t fast_intr_o;
  ao_periph_pkg::gpio_t      gpio_i;
  ao_periph_pkg::gpio_t      gpio_o;
  ao_periph_pkg::gpio_t      gpio_en_o;
  ao_periph_pkg::gpio_t      intr_gpio_o;

  // Register model
  logic                      exit_valid_m;
  ao_periph_pkg::data_t      exit_value_m;
  logic                      boot_m;
  logic                      en_m;
  ao_periph_pkg::data_t      compare_m;
  ao_periph_pkg::fast_intr_t pending_m;
  ao_periph_pkg::fast_intr_t fi_en_m;
  ao_periph_pkg::gpio_t      pins_m;
  ao_periph_pkg::gpio_t      out_m;
  ao_periph_pkg::gpio_t      dir_m;
  ao_periph_pkg::gpio_t      ie_m;

  // Outstanding responses in issue order
  ao_periph_pkg::data_t      exp_q[$];
  logic                      chk_q[$];
  string                     name_q[$];
  logic                      prev_req;
  ao_periph_pkg::data_t      last_rdata;
  int unsigned               cycle_cnt = 0;

  ao_peripheral_subsystem i_dut (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .bus_req_i     (bus_req_i),
    .bus_rsp_o     (bus_rsp_o),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o),
    .timer_intr_o  (timer_intr_o),
    .fast_intr_i   (fast_intr_i),
    .fast_intr_o   (fast_intr_o),
    .gpio_i        (gpio_i),
    .gpio_o        (gpio_o),
    .gpio_en_o     (gpio_en_o),
    .intr_gpio_o   (intr_gpio_o)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input ao_periph_pkg::data_t got,
                             input ao_periph_pkg::data_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic ao_periph_pkg::addr_t reg_addr(input int blk, input int off);
    return ao_periph_pkg::addr_t'((blk << `AO_BLK_LSB) | (off << 2));
  endfunction

  function automatic ao_periph_pkg::data_t merge_bytes(input ao_periph_pkg::data_t old_v,
                                                       input ao_periph_pkg::data_t new_v,
                                                       input ao_periph_pkg::be_t be);
    ao_periph_pkg::data_t res;
    res = old_v;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic ao_periph_pkg::data_t model_read(input ao_periph_pkg::addr_t a);
    int                   blk;
    int                   off;
    ao_periph_pkg::data_t v;
    blk = int'(a[`AO_BLK_LSB +: `AO_BLK_W]);
    off = int'(a[2 +: `AO_OFF_W]);
    v = '0;
    case (blk)
      `AO_BLK_SOC: begin
        if (off == `AO_SOC_EXIT_VALID) v = ao_periph_pkg::data_t'(exit_valid_m);
        if (off == `AO_SOC_EXIT_VALUE) v = exit_value_m;
        if (off == `AO_SOC_BOOT_SEL) v = ao_periph_pkg::data_t'(boot_m);
      end
      `AO_BLK_TIMER: begin
        if (off == `AO_TMR_CTRL) v = ao_periph_pkg::data_t'(en_m);
        if (off == `AO_TMR_COMPARE) v = compare_m;
      end
      `AO_BLK_FINTR: begin
        if (off == `AO_FI_PENDING) v = ao_periph_pkg::data_t'(pending_m);
        if (off == `AO_FI_ENABLE) v = ao_periph_pkg::data_t'(fi_en_m);
      end
      `AO_BLK_GPIO: begin
        if (off == `AO_GPIO_IN) v = ao_periph_pkg::data_t'(pins_m);
        if (off == `AO_GPIO_OUT) v = ao_periph_pkg::data_t'(out_m);
        if (off == `AO_GPIO_EN) v = ao_periph_pkg::data_t'(dir_m);
        if (off == `AO_GPIO_INTR_EN) v = ao_periph_pkg::data_t'(ie_m);
      end
      default: ;
    endcase
    return v;
  endfunction

  // Unmapped blocks and offsets leave the model untouched
  function automatic void model_write(input ao_periph_pkg::addr_t a,
                                      input ao_periph_pkg::data_t wd,
                                      input ao_periph_pkg::be_t be);
    int                   blk;
    int                   off;
    ao_periph_pkg::data_t m;
    blk = int'(a[`AO_BLK_LSB +: `AO_BLK_W]);
    off = int'(a[2 +: `AO_OFF_W]);
    case (blk)
      `AO_BLK_SOC: begin
        m = merge_bytes(ao_periph_pkg::data_t'(exit_valid_m), wd, be);
        if (off == `AO_SOC_EXIT_VALID) exit_valid_m = m[0];
        if (off == `AO_SOC_EXIT_VALUE) exit_value_m = merge_bytes(exit_value_m, wd, be);
      end
      `AO_BLK_TIMER: begin
        m = merge_bytes(ao_periph_pkg::data_t'(en_m), wd, be);
        if (off == `AO_TMR_CTRL) en_m = m[0];
        if (off == `AO_TMR_COMPARE) compare_m = merge_bytes(compare_m, wd, be);
      end
      `AO_BLK_FINTR: begin
        // Write 1 to clear under the byte enables
        m = wd & merge_bytes('0, '1, be);
        if (off == `AO_FI_PENDING) pending_m = pending_m & ~m[`AO_FINTR_W-1:0];
        m = merge_bytes(ao_periph_pkg::data_t'(fi_en_m), wd, be);
        if (off == `AO_FI_ENABLE) fi_en_m = m[`AO_FINTR_W-1:0];
      end
      `AO_BLK_GPIO: begin
        m = merge_bytes(ao_periph_pkg::data_t'(out_m), wd, be);
        if (off == `AO_GPIO_OUT) out_m = m[`AO_GPIO_W-1:0];
        m = merge_bytes(ao_periph_pkg::data_t'(dir_m), wd, be);
        if (off == `AO_GPIO_EN) dir_m = m[`AO_GPIO_W-1:0];
        m = merge_bytes(ao_periph_pkg::data_t'(ie_m), wd, be);
        if (off == `AO_GPIO_INTR_EN) ie_m = m[`AO_GPIO_W-1:0];
      end
      default: ;
    endcase
  endfunction

  function automatic ao_periph_pkg::addr_t writable_addr(input int idx);
    ao_periph_pkg::addr_t a;
    case (idx)
      0: a = reg_addr(`AO_BLK_SOC, `AO_SOC_EXIT_VALUE);
      1: a = reg_addr(`AO_BLK_TIMER, `AO_TMR_COMPARE);
      2: a = reg_addr(`AO_BLK_FINTR, `AO_FI_ENABLE);
      3: a = reg_addr(`AO_BLK_GPIO, `AO_GPIO_OUT);
      4: a = reg_addr(`AO_BLK_GPIO, `AO_GPIO_EN);
      default: a = reg_addr(`AO_BLK_GPIO, `AO_GPIO_INTR_EN);
    endcase
    return a;
  endfunction

  // First offset past the last register of a block
  function automatic int first_unmapped(input int blk);
    int off;
    case (blk)
      `AO_BLK_SOC: off = `AO_SOC_BOOT_SEL + 1;
      `AO_BLK_TIMER: off = `AO_TMR_STATUS + 1;
      `AO_BLK_FINTR: off = `AO_FI_ENABLE + 1;
      default: off = `AO_GPIO_INTR_EN + 1;
    endcase
    return off;
  endfunction

  task automatic issue(input logic we, input ao_periph_pkg::addr_t a,
                       input ao_periph_pkg::data_t wd, input ao_periph_pkg::be_t be,
                       input logic chk, input ao_periph_pkg::data_t exp, input string name);
    @(posedge clk_i);
    bus_req_i <= '{req: 1'b1, we: we, be: be, addr: a, wdata: wd};
    exp_q.push_back(exp);
    chk_q.push_back(chk);
    name_q.push_back(name);
  endtask

  task automatic write_reg(input ao_periph_pkg::addr_t a, input ao_periph_pkg::data_t wd,
                           input ao_periph_pkg::be_t be);
    model_write(a, wd, be);
    issue(1'b1, a, wd, be, 1'b0, '0, "");
  endtask

  task automatic read_model(input ao_periph_pkg::addr_t a);
    issue(1'b0, a, '0, '0, 1'b1, model_read(a), $sformatf("bus_rsp_o.rdata@%h", a));
  endtask

  // Drop req and wait until every response is back
  task automatic finish_ops();
    @(posedge clk_i);
    bus_req_i.req <= 1'b0;
    while (exp_q.size() != 0) begin
      @(negedge clk_i);
    end
  endtask

  task automatic read_reg(input ao_periph_pkg::addr_t a, output ao_periph_pkg::data_t v);
    issue(1'b0, a, '0, '0, 1'b0, '0, "");
    finish_ops();
    v = last_rdata;
  endtask

  task automatic check_pins();
    check_value("gpio_o", ao_periph_pkg::data_t'(gpio_o), ao_periph_pkg::data_t'(out_m));
    check_value("gpio_en_o", ao_periph_pkg::data_t'(gpio_en_o), ao_periph_pkg::data_t'(dir_m));
    check_value("intr_gpio_o", ao_periph_pkg::data_t'(intr_gpio_o),
                ao_periph_pkg::data_t'(pins_m & ie_m));
    check_value("fast_intr_o", ao_periph_pkg::data_t'(fast_intr_o),
                ao_periph_pkg::data_t'(pending_m & fi_en_m));
  endtask

  // Response monitor expects rvalid exactly one cycle after each request
  always @(negedge clk_i) begin
    check_value("bus_rsp_o.gnt", ao_periph_pkg::data_t'(bus_rsp_o.gnt),
                ao_periph_pkg::data_t'(bus_req_i.req));
    if (prev_req) begin
      if (bus_rsp_o.rvalid !== 1'b1) begin
        abort_run("rvalid missing one cycle after a bus request");
      end
      last_rdata = bus_rsp_o.rdata;
      if (chk_q[0]) begin
        check_value(name_q[0], bus_rsp_o.rdata, exp_q[0]);
      end
      void'(exp_q.pop_front());
      void'(chk_q.pop_front());
      void'(name_q.pop_front());
    end else if (bus_rsp_o.rvalid !== 1'b0) begin
      abort_run("rvalid raised without a bus request in the cycle before");
    end
    prev_req = bus_req_i.req;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    abort_run("watchdog expired before the tests completed");
  end

  initial begin
    ao_periph_pkg::data_t      st;
    ao_periph_pkg::data_t      cnt;
    ao_periph_pkg::fast_intr_t pulse;
    int                        off;
    int                        cmp;
    int unsigned               t_start;
    logic                      done;
    void'($urandom(706));
    rst_n_i = 1'b0;
    bus_req_i = '0;
    boot_select_i = 1'b0;
    fast_intr_i = '0;
    gpio_i = '0;
    prev_req = 1'b0;
    {exit_valid_m, exit_value_m, boot_m, en_m, compare_m} = '0;
    {pending_m, fi_en_m, pins_m, out_m, dir_m, ie_m} = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Reset values and unmapped space
    @(negedge clk_i);
    check_value("bus_rsp_o.rvalid", ao_periph_pkg::data_t'(bus_rsp_o.rvalid), '0);
    check_value("exit_valid_o", ao_periph_pkg::data_t'(exit_valid_o), '0);
    check_value("exit_value_o", exit_value_o, '0);
    check_value("timer_intr_o", ao_periph_pkg::data_t'(timer_intr_o), '0);
    check_pins();
    for (int i = 0; i < N_UNMAPPED / 2; i++) begin
      write_reg(reg_addr($urandom_range(15, 4), $urandom_range(63)), $urandom, 4'hf);
      read_model(reg_addr($urandom_range(15, 4), $urandom_range(63)));
    end
    for (int b = 0; b < `AO_NUM_BLK; b++) begin
      off = $urandom_range(63, first_unmapped(b));
      write_reg(reg_addr(b, off), $urandom, 4'hf);
      read_model(reg_addr(b, off));
    end
    finish_ops();

    // Back-to-back random writes and reads
    for (int i = 0; i < N_RAND; i++) begin
      if ($urandom_range(1) == 1) begin
        write_reg(writable_addr($urandom_range(5)), $urandom, ao_periph_pkg::be_t'($urandom));
      end else begin
        read_model(writable_addr($urandom_range(5)));
      end
    end
    for (int i = 0; i < 6; i++) begin
      read_model(writable_addr(i));
    end
    finish_ops();
    check_pins();

    // System control
    write_reg(reg_addr(`AO_BLK_SOC, `AO_SOC_EXIT_VALUE), $urandom,
              ao_periph_pkg::be_t'($urandom));
    write_reg(reg_addr(`AO_BLK_SOC, `AO_SOC_EXIT_VALID), 32'h1,
              4'h1 | ao_periph_pkg::be_t'($urandom));
    finish_ops();
    check_value("exit_valid_o", ao_periph_pkg::data_t'(exit_valid_o),
                ao_periph_pkg::data_t'(exit_valid_m));
    check_value("exit_value_o", exit_value_o, exit_value_m);
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      boot_m = $urandom_range(1);
      boot_select_i <= boot_m;
      read_model(reg_addr(`AO_BLK_SOC, `AO_SOC_BOOT_SEL));
      finish_ops();
    end

    // GPIO pins held long enough to pass the synchroniser
    for (int i = 0; i < N_GPIO; i++) begin
      write_reg(reg_addr(`AO_BLK_GPIO, `AO_GPIO_INTR_EN), $urandom,
                ao_periph_pkg::be_t'($urandom));
      finish_ops();
      @(posedge clk_i);
      pins_m = ao_periph_pkg::gpio_t'($urandom);
      gpio_i <= pins_m;
      repeat (3) @(posedge clk_i);
      read_model(reg_addr(`AO_BLK_GPIO, `AO_GPIO_IN));
      finish_ops();
      check_pins();
    end

    // Fast interrupt pulses followed by a partial clear
    write_reg(reg_addr(`AO_BLK_FINTR, `AO_FI_ENABLE), $urandom, ao_periph_pkg::be_t'($urandom));
    finish_ops();
    for (int i = 0; i < N_PULSE; i++) begin
      @(posedge clk_i);
      pulse = ao_periph_pkg::fast_intr_t'($urandom & $urandom);
      fast_intr_i <= pulse;
      @(posedge clk_i);
      fast_intr_i <= '0;
      pending_m = pending_m | pulse;
      @(negedge clk_i);
      check_pins();
    end
    read_model(reg_addr(`AO_BLK_FINTR, `AO_FI_PENDING));
    write_reg(reg_addr(`AO_BLK_FINTR, `AO_FI_PENDING), $urandom, ao_periph_pkg::be_t'($urandom));
    read_model(reg_addr(`AO_BLK_FINTR, `AO_FI_PENDING));
    finish_ops();
    check_pins();

    // Timer from count zero up to a small compare value
    cmp = $urandom_range(MAX_CMP, 8);
    write_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_CTRL), '0, 4'hf);
    issue(1'b1, reg_addr(`AO_BLK_TIMER, `AO_TMR_COUNT), '0, 4'hf, 1'b0, '0, "");
    write_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_COMPARE), cmp, 4'hf);
    t_start = cycle_cnt;
    write_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_CTRL), 32'h1, 4'hf);
    finish_ops();
    done = 1'b0;
    while (!done) begin
      read_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_STATUS), st);
      read_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_COUNT), cnt);
      if (cnt < ao_periph_pkg::data_t'(cmp)) begin
        check_value("timer status", st, '0);
      end
      if (st == 32'h1) begin
        done = 1'b1;
      end else if (cycle_cnt - t_start > cmp + 16) begin
        abort_run("timer status did not set after the count reached compare");
      end
    end
    check_value("timer_intr_o", ao_periph_pkg::data_t'(timer_intr_o), 32'h1);
    write_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_CTRL), '0, 4'hf);
    issue(1'b1, reg_addr(`AO_BLK_TIMER, `AO_TMR_STATUS), 32'h1, 4'h1, 1'b0, '0, "");
    read_model(reg_addr(`AO_BLK_TIMER, `AO_TMR_CTRL));
    finish_ops();
    read_reg(reg_addr(`AO_BLK_TIMER, `AO_TMR_STATUS), st);
    check_value("timer status", st, '0);
    check_value("timer_intr_o", ao_periph_pkg::data_t'(timer_intr_o), '0);

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// ==== source/ao_peripheral_subsystem.sv ====
//********************************************************************
// Always-on peripheral subsystem: bus control in front of system
// control, timer, fast interrupt and GPIO register blocks
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module ao_peripheral_subsystem (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ao_periph_pkg::obi_req_t   bus_req_i,
  output ao_periph_pkg::obi_rsp_t   bus_rsp_o,
  input  logic                      boot_select_i,
  output logic                      exit_valid_o,
  output ao_periph_pkg::data_t      exit_value_o,
  output logic                      timer_intr_o,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o,
  input  ao_periph_pkg::gpio_t      gpio_i,
  output ao_periph_pkg::gpio_t      gpio_o,
  output ao_periph_pkg::gpio_t      gpio_en_o,
  output ao_periph_pkg::gpio_t      intr_gpio_o
);

  // One request and response slot per block
  ao_periph_pkg::reg_req_t [`AO_NUM_BLK-1:0] blk_req;
  ao_periph_pkg::reg_rsp_t [`AO_NUM_BLK-1:0] blk_rsp;

  ao_bus_ctrl i_bus_ctrl (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .blk_req_o (blk_req),
    .blk_rsp_i (blk_rsp)
  );

  soc_ctrl_regs i_soc_ctrl (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .reg_req_i     (blk_req[`AO_BLK_SOC]),
    .reg_rsp_o     (blk_rsp[`AO_BLK_SOC]),
    .boot_select_i (boot_select_i),
    .exit_valid_o  (exit_valid_o),
    .exit_value_o  (exit_value_o)
  );

  ao_timer i_timer (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .reg_req_i    (blk_req[`AO_BLK_TIMER]),
    .reg_rsp_o    (blk_rsp[`AO_BLK_TIMER]),
    .timer_intr_o (timer_intr_o)
  );

  fast_intr_ctrl i_fast_intr_ctrl (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (blk_req[`AO_BLK_FINTR]),
    .reg_rsp_o   (blk_rsp[`AO_BLK_FINTR]),
    .fast_intr_i (fast_intr_i),
    .fast_intr_o (fast_intr_o)
  );

  gpio_ao i_gpio (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .reg_req_i   (blk_req[`AO_BLK_GPIO]),
    .reg_rsp_o   (blk_rsp[`AO_BLK_GPIO]),
    .gpio_i      (gpio_i),
    .gpio_o      (gpio_o),
    .gpio_en_o   (gpio_en_o),
    .intr_gpio_o (intr_gpio_o)
  );

endmodule

// ==== source/gpio_ao.sv ====
//********************************************************************
// Always-on GPIO: output and direction registers, synchronised
// input and per-pin level interrupts
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module gpio_ao (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  ao_periph_pkg::gpio_t    gpio_i,
  output ao_periph_pkg::gpio_t    gpio_o,
  output ao_periph_pkg::gpio_t    gpio_en_o,
  output ao_periph_pkg::gpio_t    intr_gpio_o
);

  logic                 wr_en;
  ao_periph_pkg::gpio_t sync_q1;
  ao_periph_pkg::gpio_t sync_q2;
  ao_periph_pkg::gpio_t out_q;
  ao_periph_pkg::gpio_t en_q;
  ao_periph_pkg::gpio_t intr_en_q;
  ao_periph_pkg::data_t out_wr;
  ao_periph_pkg::data_t en_wr;
  ao_periph_pkg::data_t intr_en_wr;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  assign out_wr     = ao_periph_pkg::be_write(ao_periph_pkg::data_t'(out_q),
                                              reg_req_i.wdata, reg_req_i.be);
  assign en_wr      = ao_periph_pkg::be_write(ao_periph_pkg::data_t'(en_q),
                                              reg_req_i.wdata, reg_req_i.be);
  assign intr_en_wr = ao_periph_pkg::be_write(ao_periph_pkg::data_t'(intr_en_q),
                                              reg_req_i.wdata, reg_req_i.be);

  // Two-stage synchroniser on the pads
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gpio_i;
      sync_q2 <= sync_q1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      en_q      <= '0;
      intr_en_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.off)
        `AO_GPIO_OUT:     out_q     <= out_wr[`AO_GPIO_W-1:0];
        `AO_GPIO_EN:      en_q      <= en_wr[`AO_GPIO_W-1:0];
        `AO_GPIO_INTR_EN: intr_en_q <= intr_en_wr[`AO_GPIO_W-1:0];
        default: ;
      endcase
    end
  end

  // Input register is read only
  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.off)
      `AO_GPIO_IN:      reg_rsp_o.rdata = ao_periph_pkg::data_t'(sync_q2);
      `AO_GPIO_OUT:     reg_rsp_o.rdata = ao_periph_pkg::data_t'(out_q);
      `AO_GPIO_EN:      reg_rsp_o.rdata = ao_periph_pkg::data_t'(en_q);
      `AO_GPIO_INTR_EN: reg_rsp_o.rdata = ao_periph_pkg::data_t'(intr_en_q);
      default: ;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = en_q;
  assign intr_gpio_o = sync_q2 & intr_en_q;

endmodule

// ==== source/fast_intr_ctrl.sv ====
//********************************************************************
// Fast interrupt controller: sticky pending bits masked by enable
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module fast_intr_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  ao_periph_pkg::reg_req_t   reg_req_i,
  output ao_periph_pkg::reg_rsp_t   reg_rsp_o,
  input  ao_periph_pkg::fast_intr_t fast_intr_i,
  output ao_periph_pkg::fast_intr_t fast_intr_o
);

  logic                      wr_en;
  ao_periph_pkg::fast_intr_t pending_q;
  ao_periph_pkg::fast_intr_t enable_q;
  ao_periph_pkg::fast_intr_t pending_clr;
  ao_periph_pkg::data_t      enable_wr;
  ao_periph_pkg::data_t      clr_mask;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  assign enable_wr = ao_periph_pkg::be_write(ao_periph_pkg::data_t'(enable_q),
                                             reg_req_i.wdata, reg_req_i.be);
  assign clr_mask  = reg_req_i.wdata & ao_periph_pkg::be_mask(reg_req_i.be);

  always_comb begin
    pending_clr = '0;
    if (wr_en && (reg_req_i.off == `AO_FI_PENDING)) begin
      pending_clr = clr_mask[`AO_FINTR_W-1:0];
    end
  end

  // A line still high wins over the clear
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      pending_q <= (pending_q & ~pending_clr) | fast_intr_i;
      if (wr_en && (reg_req_i.off == `AO_FI_ENABLE)) begin
        enable_q <= enable_wr[`AO_FINTR_W-1:0];
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.off)
      `AO_FI_PENDING: reg_rsp_o.rdata = ao_periph_pkg::data_t'(pending_q);
      `AO_FI_ENABLE:  reg_rsp_o.rdata = ao_periph_pkg::data_t'(enable_q);
      default: ;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

// ==== source/ao_timer.sv ====
//********************************************************************
// Compare timer: 32-bit counter with enable and load, sticky
// status bit on a match drives the interrupt
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module ao_timer (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                    timer_intr_o
);

  logic                 wr_en;
  logic                 en_q;
  logic                 status_q;
  ao_periph_pkg::data_t count_q;
  ao_periph_pkg::data_t compare_q;
  ao_periph_pkg::data_t ctrl_wr;
  ao_periph_pkg::data_t count_wr;
  ao_periph_pkg::data_t compare_wr;
  logic                 match;
  logic                 status_clr;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  assign ctrl_wr    = ao_periph_pkg::be_write(ao_periph_pkg::data_t'(en_q),
                                              reg_req_i.wdata, reg_req_i.be);
  assign count_wr   = ao_periph_pkg::be_write(count_q, reg_req_i.wdata, reg_req_i.be);
  assign compare_wr = ao_periph_pkg::be_write(compare_q, reg_req_i.wdata, reg_req_i.be);

  assign match      = en_q && (count_q == compare_q);
  // Write 1 to clear, only through byte lane 0
  assign status_clr = wr_en && (reg_req_i.off == `AO_TMR_STATUS) &&
                      reg_req_i.wdata[0] && reg_req_i.be[0];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      en_q      <= 1'b0;
      count_q   <= '0;
      compare_q <= '0;
      status_q  <= 1'b0;
    end else begin
      if (wr_en && (reg_req_i.off == `AO_TMR_CTRL)) begin
        en_q <= ctrl_wr[0];
      end
      // Software load beats the increment
      if (wr_en && (reg_req_i.off == `AO_TMR_COUNT)) begin
        count_q <= count_wr;
      end else if (en_q) begin
        count_q <= count_q + 1'b1;
      end
      if (wr_en && (reg_req_i.off == `AO_TMR_COMPARE)) begin
        compare_q <= compare_wr;
      end
      if (match) begin
        status_q <= 1'b1;
      end else if (status_clr) begin
        status_q <= 1'b0;
      end
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.off)
      `AO_TMR_CTRL:    reg_rsp_o.rdata = ao_periph_pkg::data_t'(en_q);
      `AO_TMR_COUNT:   reg_rsp_o.rdata = count_q;
      `AO_TMR_COMPARE: reg_rsp_o.rdata = compare_q;
      `AO_TMR_STATUS:  reg_rsp_o.rdata = ao_periph_pkg::data_t'(status_q);
      default: ;
    endcase
  end

  assign timer_intr_o = status_q;

endmodule

// ==== source/soc_ctrl_regs.sv ====
//********************************************************************
// System control registers: exit flag, exit value, boot select
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module soc_ctrl_regs (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  ao_periph_pkg::reg_req_t reg_req_i,
  output ao_periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic                    boot_select_i,
  output logic                    exit_valid_o,
  output ao_periph_pkg::data_t    exit_value_o
);

  logic                 wr_en;
  logic                 exit_valid_q;
  ao_periph_pkg::data_t exit_value_q;
  ao_periph_pkg::data_t exit_valid_wr;
  ao_periph_pkg::data_t exit_value_wr;

  assign wr_en = reg_req_i.valid && reg_req_i.write;

  assign exit_valid_wr = ao_periph_pkg::be_write(ao_periph_pkg::data_t'(exit_valid_q),
                                                 reg_req_i.wdata, reg_req_i.be);
  assign exit_value_wr = ao_periph_pkg::be_write(exit_value_q, reg_req_i.wdata, reg_req_i.be);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      case (reg_req_i.off)
        `AO_SOC_EXIT_VALID: exit_valid_q <= exit_valid_wr[0];
        `AO_SOC_EXIT_VALUE: exit_value_q <= exit_value_wr;
        default: ;
      endcase
    end
  end

  always_comb begin
    reg_rsp_o.rdata = '0;
    case (reg_req_i.off)
      `AO_SOC_EXIT_VALID: reg_rsp_o.rdata = ao_periph_pkg::data_t'(exit_valid_q);
      `AO_SOC_EXIT_VALUE: reg_rsp_o.rdata = exit_value_q;
      `AO_SOC_BOOT_SEL:   reg_rsp_o.rdata = ao_periph_pkg::data_t'(boot_select_i);
      default: ;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// ==== source/ao_bus_ctrl.sv ====
//********************************************************************
// Bus front end: decodes block and offset, grants at once and
// returns the registered read data one cycle later
//********************************************************************
`timescale 1ns/100ps
`include "ao_periph_macros.svh"

module ao_bus_ctrl (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  ao_periph_pkg::obi_req_t                  bus_req_i,
  output ao_periph_pkg::obi_rsp_t                  bus_rsp_o,
  output ao_periph_pkg::reg_req_t [`AO_NUM_BLK-1:0] blk_req_o,
  input  ao_periph_pkg::reg_rsp_t [`AO_NUM_BLK-1:0] blk_rsp_i
);

  ao_periph_pkg::blk_sel_t blk_sel;
  ao_periph_pkg::reg_off_t reg_off;
  ao_periph_pkg::data_t    rdata_sel;
  ao_periph_pkg::data_t    rdata_q;
  logic                    rvalid_q;

  assign blk_sel = bus_req_i.addr[`AO_BLK_LSB +: `AO_BLK_W];
  // Word offset sits just above the byte lane bits
  assign reg_off = bus_req_i.addr[2 +: `AO_OFF_W];

  // Fan the request out, only the addressed block sees valid
  always_comb begin
    for (int i = 0; i < `AO_NUM_BLK; i++) begin
      blk_req_o[i].valid = bus_req_i.req && (blk_sel == ao_periph_pkg::blk_sel_t'(i));
      blk_req_o[i].write = bus_req_i.we;
      blk_req_o[i].off   = reg_off;
      blk_req_o[i].wdata = bus_req_i.wdata;
      blk_req_o[i].be    = bus_req_i.be;
    end
  end

  // Read mux, indices past the last block fall through to zero
  always_comb begin
    rdata_sel = '0;
    for (int i = 0; i < `AO_NUM_BLK; i++) begin
      if (blk_sel == ao_periph_pkg::blk_sel_t'(i)) begin
        rdata_sel = blk_rsp_i[i].rdata;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus_req_i.req;
    end
  end

  // Writes return zero data
  always_ff @(posedge clk_i) begin
    if (bus_req_i.req) begin
      rdata_q <= bus_req_i.we ? '0 : rdata_sel;
    end
  end

  // No back-pressure, every request is taken right away
  assign bus_rsp_o.gnt    = bus_req_i.req;
  assign bus_rsp_o.rvalid = rvalid_q;
  assign bus_rsp_o.rdata  = rdata_q;

endmodule

// ==== source/ao_periph_pkg.sv ====
//********************************************************************
// Always-on peripheral types: bus words, register request and
// response structs, byte-enable write helpers
//********************************************************************
`include "ao_periph_macros.svh"

package ao_periph_pkg;

  typedef logic [`AO_DATA_W-1:0] data_t;
  typedef logic [`AO_ADDR_W-1:0] addr_t;
  typedef logic [`AO_DATA_W/8-1:0] be_t;
  typedef logic [`AO_OFF_W-1:0] reg_off_t;
  typedef logic [`AO_BLK_W-1:0] blk_sel_t;
  typedef logic [`AO_GPIO_W-1:0] gpio_t;
  typedef logic [`AO_FINTR_W-1:0] fast_intr_t;

  // Bus master side
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_rsp_t;

  // Register block side
  typedef struct packed {
    logic     valid;
    logic     write;
    reg_off_t off;
    data_t    wdata;
    be_t      be;
  } reg_req_t;

  typedef struct packed {
    data_t rdata;
  } reg_rsp_t;

  // Expand byte enables to a bit mask
  function automatic data_t be_mask(be_t be);
    data_t mask;
    for (int i = 0; i < $bits(be_t); i++) begin
      mask[8*i +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

  // New register value after a byte-enabled write
  function automatic data_t be_write(data_t old, data_t wdata, be_t be);
    data_t mask;
    mask = be_mask(be);
    return (old & ~mask) | (wdata & mask);
  endfunction

endpackage

// ==== source/ao_periph_macros.svh ====
//********************************************************************
// Always-on peripheral subsystem constants: bus widths, block map
// and word offsets of every register
//********************************************************************
`ifndef AO_PERIPH_MACROS_SVH
`define AO_PERIPH_MACROS_SVH

// Bus widths
`define AO_DATA_W 32
`define AO_ADDR_W 32

// Address fields
`define AO_BLK_LSB 8
`define AO_BLK_W 4
`define AO_OFF_W 6

// Block map
`define AO_NUM_BLK 4
`define AO_BLK_SOC 0
`define AO_BLK_TIMER 1
`define AO_BLK_FINTR 2
`define AO_BLK_GPIO 3

// Pin and line counts
`define AO_GPIO_W 8
`define AO_FINTR_W 15

// System control
`define AO_SOC_EXIT_VALID 0
`define AO_SOC_EXIT_VALUE 1
`define AO_SOC_BOOT_SEL 2

// Timer
`define AO_TMR_CTRL 0
`define AO_TMR_COUNT 1
`define AO_TMR_COMPARE 2
`define AO_TMR_STATUS 3

// Fast interrupt controller
`define AO_FI_PENDING 0
`define AO_FI_ENABLE 1

// GPIO
`define AO_GPIO_IN 0
`define AO_GPIO_OUT 1
`define AO_GPIO_EN 2
`define AO_GPIO_INTR_EN 3

`endif
